// File: hw/dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    parameter int DCACHE_WAYS = 2;
    parameter int OFFSET_W    = 4;
    parameter int INDEX_W     = 8;
    parameter int TAG_W       = 32 - INDEX_W - OFFSET_W;  // 20
    parameter int LINE_BYTES  = 1 << OFFSET_W;
    parameter int LINE_W      = LINE_BYTES * 8;

    typedef struct packed {
        logic        we;     // 1: store, 0: load
        logic [31:0] addr;
        logic [3:0]  strb;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic [31:0]           addr;  // word aligned
        logic [LINE_W-1:0]     data;
        logic [LINE_BYTES-1:0] strb;
    } mem_wr_t;

    typedef struct packed {
        logic                  tag_we;
        tag_entry_t            tag;
        logic [LINE_BYTES-1:0] byte_we;
        logic [LINE_W-1:0]     line;
    } way_wr_t;

    function automatic logic [INDEX_W-1:0] addr_index(logic [31:0] addr);
        return addr[OFFSET_W +: INDEX_W];
    endfunction

    function automatic logic [TAG_W-1:0] addr_tag(logic [31:0] addr);
        return addr[OFFSET_W + INDEX_W +: TAG_W];
    endfunction

    // bits needed to number the ways, never zero
    function automatic int way_idx_w(int ways);
        return (ways > 1) ? $clog2(ways) : 1;
    endfunction

endpackage

`default_nettype wire

// File: hw/dcache_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  ADDR_W  = 8
) (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [ADDR_W-1:0] addr,
    input  entry_t            wdata,
    output entry_t            rdata
);

    entry_t mem [2**ADDR_W];

    // read-first, rdata shows the entry as it was before the write
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: hw/dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_way
    import dcache_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               en,
    input  logic [INDEX_W-1:0] index,
    input  logic [TAG_W-1:0]   lookup_tag,
    input  way_wr_t            wr,
    output logic               hit,
    output logic [LINE_W-1:0]  line,
    output logic               busy
);

    logic [INDEX_W-1:0] sweep_idx;
    logic               sweeping;
    logic [INDEX_W-1:0] tag_addr;
    tag_entry_t         tag_wdata;
    tag_entry_t         tag_q;
    logic [LINE_BYTES-1:0][7:0] lane_q;

    // clear every valid bit once after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) sweeping <= 1'b0;
        end
    end

    assign busy      = sweeping;
    assign tag_addr  = sweeping ? sweep_idx : index;
    assign tag_wdata = sweeping ? '0 : wr.tag;

    dcache_ram #(
        .entry_t(tag_entry_t),
        .ADDR_W (INDEX_W)
    ) u_tag_ram (
        .clk  (clk),
        .en   (en | sweeping),
        .we   (wr.tag_we | sweeping),
        .addr (tag_addr),
        .wdata(tag_wdata),
        .rdata(tag_q)
    );

    for (genvar b = 0; b < LINE_BYTES; b++) begin : g_lane
        dcache_ram #(
            .entry_t(logic [7:0]),
            .ADDR_W (INDEX_W)
        ) u_lane_ram (
            .clk  (clk),
            .en   (en),
            .we   (wr.byte_we[b]),
            .addr (index),
            .wdata(wr.line[8*b +: 8]),
            .rdata(lane_q[b])
        );
    end

    assign line = lane_q;
    assign hit  = tag_q.valid && (tag_q.tag == lookup_tag);

endmodule

`default_nettype wire

// File: hw/dcache_victim_lfsr.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_victim_lfsr
    import dcache_pkg::*;
#(
    parameter int          NUM_WAYS = DCACHE_WAYS,
    parameter logic [15:0] SEED     = 16'hace1
) (
    input  logic                           clk,
    input  logic                           rst,
    output logic [way_idx_w(NUM_WAYS)-1:0] victim
);

    localparam int VICTIM_W = way_idx_w(NUM_WAYS);

    logic [15:0] lfsr_q;

    // galois form, x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr_q <= SEED;
        end else begin
            lfsr_q <= (lfsr_q >> 1) ^ (lfsr_q[0] ? 16'hb400 : 16'h0000);
        end
    end

    assign victim = lfsr_q[VICTIM_W-1:0];

endmodule

`default_nettype wire

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
#(
    parameter int NUM_WAYS = DCACHE_WAYS
) (
    input  logic                                  clk,
    input  logic                                  rst,

    input  logic                                  req_valid,
    input  cpu_req_t                              req,
    output logic                                  ready,
    output logic                                  data_ok,
    output logic [31:0]                           rdata,

    output logic                                  way_en,
    output logic [INDEX_W-1:0]                    way_index,
    output logic [TAG_W-1:0]                      lookup_tag,
    output way_wr_t [NUM_WAYS-1:0]                way_wr,
    input  logic [NUM_WAYS-1:0]                   way_hit,
    input  logic [NUM_WAYS-1:0][LINE_W-1:0]       way_line,
    input  logic [NUM_WAYS-1:0]                   way_busy,
    input  logic [way_idx_w(NUM_WAYS)-1:0]        victim,

    output logic                                  rd_req,
    output logic [31:0]                           rd_addr,
    input  logic                                  rd_rdy,
    input  logic                                  ret_valid,
    input  logic [LINE_W-1:0]                     ret_data,

    output logic                                  wr_req,
    output mem_wr_t                               wr,
    input  logic                                  wr_rdy
);

    localparam int VICTIM_W = way_idx_w(NUM_WAYS);

    typedef enum logic [2:0] {
        IDLE,
        LOOK_UP,
        READ_REQ,
        READ_WAIT,
        WRITE_REQ
    } state_t;

    state_t              state, next_state;
    cpu_req_t            req_q;
    logic [NUM_WAYS-1:0] hit_q;
    logic                accept;
    logic                any_hit;
    logic [1:0]          word_sel;
    logic [LINE_W-1:0]   hit_line;
    logic [LINE_W-1:0]   src_line;

    assign ready    = (state == IDLE) && !(|way_busy);  // held off while valid bits clear
    assign accept   = req_valid && ready;
    assign any_hit  = |way_hit;
    assign word_sel = req_q.addr[3:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            hit_q <= '0;
        end else begin
            state <= next_state;
            if (state == LOOK_UP) hit_q <= way_hit;  // kept for the store merge
        end
    end

    always_ff @(posedge clk) begin
        if (accept) req_q <= req;
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (accept) next_state = LOOK_UP;
            LOOK_UP: begin
                if (req_q.we) next_state = WRITE_REQ;
                else if (any_hit) next_state = IDLE;
                else next_state = READ_REQ;
            end
            READ_REQ:  if (rd_rdy) next_state = READ_WAIT;
            READ_WAIT: if (ret_valid) next_state = IDLE;
            WRITE_REQ: if (wr_rdy) next_state = IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // tag and data RAMs are read on the accept edge, so lookup sees them in LOOK_UP
    assign way_en     = (state == IDLE) ? accept : 1'b1;
    assign way_index  = (state == IDLE) ? addr_index(req.addr) : addr_index(req_q.addr);
    assign lookup_tag = addr_tag(req_q.addr);

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (way_hit[w]) hit_line |= way_line[w];
        end
    end

    assign src_line = (state == READ_WAIT) ? ret_data : hit_line;
    assign rdata    = src_line[32*word_sel +: 32];

    always_comb begin
        data_ok = 1'b0;
        case (state)
            LOOK_UP:   data_ok = !req_q.we && any_hit;
            READ_WAIT: data_ok = ret_valid;
            WRITE_REQ: data_ok = wr_rdy;
            default:   data_ok = 1'b0;
        endcase
    end

    assign rd_req  = (state == READ_REQ);
    assign rd_addr = {req_q.addr[31:OFFSET_W], {OFFSET_W{1'b0}}};  // line aligned

    // word placed in its lane of the 128-bit write
    assign wr_req  = (state == WRITE_REQ);
    assign wr.addr = {req_q.addr[31:2], 2'b00};
    assign wr.data = LINE_W'(req_q.wdata) << (32 * word_sel);
    assign wr.strb = LINE_BYTES'(req_q.strb) << (4 * word_sel);

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_wr[w] = '0;
            if (state == READ_WAIT && ret_valid && victim == VICTIM_W'(w)) begin
                way_wr[w].tag_we  = 1'b1;
                way_wr[w].tag     = '{valid: 1'b1, tag: lookup_tag};
                way_wr[w].byte_we = '1;
                way_wr[w].line    = ret_data;
            end else if (state == WRITE_REQ && wr_rdy && hit_q[w]) begin
                way_wr[w].byte_we = wr.strb;  // tag untouched, bytes merged
                way_wr[w].line    = wr.data;
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/wt_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module wt_dcache
    import dcache_pkg::*;
#(
    parameter int          NUM_WAYS  = DCACHE_WAYS,
    parameter logic [15:0] LFSR_SEED = 16'hace1
) (
    input  logic              clk,
    input  logic              rst,

    input  logic              req_valid,
    input  cpu_req_t          req,
    output logic              ready,
    output logic              data_ok,
    output logic [31:0]       rdata,

    output logic              rd_req,
    output logic [31:0]       rd_addr,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  logic [LINE_W-1:0] ret_data,

    output logic              wr_req,
    output mem_wr_t           wr,
    input  logic              wr_rdy
);

    localparam int VICTIM_W = way_idx_w(NUM_WAYS);

    logic                            way_en;
    logic [INDEX_W-1:0]              way_index;
    logic [TAG_W-1:0]                lookup_tag;
    way_wr_t [NUM_WAYS-1:0]          way_wr;
    logic [NUM_WAYS-1:0]             way_hit;
    logic [NUM_WAYS-1:0][LINE_W-1:0] way_line;
    logic [NUM_WAYS-1:0]             way_busy;
    logic [VICTIM_W-1:0]             victim;

    dcache_ctrl #(
        .NUM_WAYS(NUM_WAYS)
    ) u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .ready     (ready),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .way_en    (way_en),
        .way_index (way_index),
        .lookup_tag(lookup_tag),
        .way_wr    (way_wr),
        .way_hit   (way_hit),
        .way_line  (way_line),
        .way_busy  (way_busy),
        .victim    (victim),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr        (wr),
        .wr_rdy    (wr_rdy)
    );

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        dcache_way u_way (
            .clk       (clk),
            .rst       (rst),
            .en        (way_en),
            .index     (way_index),
            .lookup_tag(lookup_tag),
            .wr        (way_wr[w]),
            .hit       (way_hit[w]),
            .line      (way_line[w]),
            .busy      (way_busy[w])
        );
    end

    dcache_victim_lfsr #(
        .NUM_WAYS(NUM_WAYS),
        .SEED    (LFSR_SEED)
    ) u_victim (
        .clk   (clk),
        .rst   (rst),
        .victim(victim)
    );

endmodule

`default_nettype wire

// File: tests/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model
    import dcache_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_hold,   // forces rd_rdy low
    input  logic              rd_req,
    input  logic [31:0]       rd_addr,
    output logic              rd_rdy,
    output logic              ret_valid,
    output logic [LINE_W-1:0] ret_data,
    input  logic              wr_req,
    input  mem_wr_t           wr,
    output logic              wr_rdy,
    output int                rd_count,
    output int                wr_count
);

    logic [31:0] store [logic [29:0]];  // sparse, keyed by word address
    int          seed;
    int          served;
    int          ret_wait;
    logic        rdy_roll;
    logic [31:0] line_addr;
    logic [29:0] waddr;
    logic [31:0] word;

    // unwritten words carry a pattern of their own address
    function automatic logic [31:0] read_word(logic [29:0] wa);
        if (store.exists(wa)) return store[wa];
        return {2'b00, wa} ^ 32'h5a5a0000;
    endfunction

    assign rd_rdy = rdy_roll && !rd_hold;

    initial begin
        seed      = 32'h62d4bcab;
        rdy_roll  = 1'b0;
        ret_valid = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        served    = 0;
        ret_wait  = 0;
    end

    always @(posedge clk) begin
        if (rst) begin
            rd_count <= 0;
            wr_count <= 0;
        end else begin
            if (rd_req && rd_rdy) begin
                rd_count  <= rd_count + 1;
                line_addr <= rd_addr;
            end
            if (wr_req && wr_rdy) begin
                wr_count <= wr_count + 1;
                for (int b = 0; b < LINE_BYTES; b++) begin
                    if (wr.strb[b]) begin
                        waddr = {wr.addr[31:4], 2'(b / 4)};
                        word  = read_word(waddr);
                        word[8*(b%4) +: 8] = wr.data[8*b +: 8];
                        store[waddr] = word;
                    end
                end
            end
        end
    end

    // responses change on the falling edge
    always @(negedge clk) begin
        ret_valid = 1'b0;
        if (rst) begin
            served   = 0;
            rdy_roll = 1'b0;
            wr_rdy   = 1'b0;
        end else begin
            rdy_roll = ($random(seed) & 1) != 0;
            wr_rdy   = ($random(seed) & 3) == 0;  // one in four
            if (served != rd_count) begin
                if (ret_wait > 0) begin
                    ret_wait--;
                end else begin
                    for (int w = 0; w < 4; w++) begin
                        ret_data[32*w +: 32] = read_word({line_addr[31:4], 2'(w)});
                    end
                    ret_valid = 1'b1;
                    served++;
                    ret_wait = $random(seed) & 7;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
();

    localparam int TIMEOUT = 1000;  // long enough for the valid-bit sweep

    logic              clk;
    logic              rst;
    logic              req_valid;
    cpu_req_t          req;
    logic              ready;
    logic              data_ok;
    logic [31:0]       rdata;
    logic              rd_req;
    logic [31:0]       rd_addr;
    logic              rd_rdy;
    logic              ret_valid;
    logic [LINE_W-1:0] ret_data;
    logic              wr_req;
    mem_wr_t           wr;
    logic              wr_rdy;
    logic              rd_hold;
    int                rd_count;
    int                wr_count;

    logic [31:0]       last_rd_addr;
    logic [31:0]       done_data;
    mem_wr_t           done_wr;
    int                done_lat;
    int                seed = 32'h62d4bcab;
    logic [31:0]       shadow [logic [29:0]];  // expected memory words

    wt_dcache #(
        .NUM_WAYS (DCACHE_WAYS),
        .LFSR_SEED(16'hace1)
    ) u_dut (
        .clk      (clk),
        .rst      (rst),
        .req_valid(req_valid),
        .req      (req),
        .ready    (ready),
        .data_ok  (data_ok),
        .rdata    (rdata),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_rdy   (rd_rdy),
        .ret_valid(ret_valid),
        .ret_data (ret_data),
        .wr_req   (wr_req),
        .wr       (wr),
        .wr_rdy   (wr_rdy)
    );

    dcache_mem_model u_mem (
        .clk      (clk),
        .rst      (rst),
        .rd_hold  (rd_hold),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .rd_rdy   (rd_rdy),
        .ret_valid(ret_valid),
        .ret_data (ret_data),
        .wr_req   (wr_req),
        .wr       (wr),
        .wr_rdy   (wr_rdy),
        .rd_count (rd_count),
        .wr_count (wr_count)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rd_req && rd_rdy) last_rd_addr <= rd_addr;
    end

    task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("CHECKS FAILED");
        $fatal(1, "wait limit reached");
    endtask

    function automatic logic [31:0] exp_word(logic [31:0] addr);
        if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
        return {2'b00, addr[31:2]} ^ 32'h5a5a0000;
    endfunction

    function automatic void shadow_write(logic [31:0] addr, logic [3:0] strb,
                                         logic [31:0] wdata);
        logic [31:0] w;
        w = exp_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) w[8*b +: 8] = wdata[8*b +: 8];
        end
        shadow[addr[31:2]] = w;
    endfunction

    // returns on the falling edge after the accepting edge
    task automatic issue_req(input logic we, input logic [31:0] addr,
                             input logic [3:0] strb, input logic [31:0] wdata);
        int t;
        @(negedge clk);
        req_valid = 1'b1;
        req = '{we: we, addr: addr, strb: strb, wdata: wdata};
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) report_timeout("the cache to accept a request");
        end while (!ready);
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    task automatic wait_done();
        int t;
        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) report_timeout("data_ok");
        end while (!data_ok);
        done_lat  = t;  // cycles after the accepting edge
        done_data = rdata;
        done_wr   = wr;
        @(negedge clk);
    endtask

    task automatic read_check(input string name, input logic [31:0] addr);
        issue_req(1'b0, addr, 4'hf, 32'h0);
        wait_done();
        check(name, exp_word(addr), done_data);
    endtask

    task automatic write_check(input string name, input logic [31:0] addr,
                               input logic [3:0] strb, input logic [31:0] wdata);
        int                    wc;
        logic [LINE_W-1:0]     exp_data;
        logic [LINE_BYTES-1:0] exp_strb;
        wc       = wr_count;
        exp_data = '0;
        exp_strb = '0;
        exp_data[32*addr[3:2] +: 32] = wdata;  // lane picked by word offset
        exp_strb[4*addr[3:2] +: 4]   = strb;
        issue_req(1'b1, addr, strb, wdata);
        wait_done();
        shadow_write(addr, strb, wdata);
        check({name, " count"}, wc + 1, wr_count);
        check({name, " addr"}, {addr[31:2], 2'b00}, done_wr.addr);
        check({name, " data"}, exp_data, done_wr.data);
        check({name, " strb"}, exp_strb, done_wr.strb);
    endtask

    task automatic test_reset();
        int t;
        t = 0;
        while (!ready) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) report_timeout("ready after reset");
        end
        check("reset data_ok", 1'b0, data_ok);
        check("reset rd_req", 1'b0, rd_req);
        check("reset wr_req", 1'b0, wr_req);
    endtask

    task automatic test_read_miss_hit();
        logic [31:0] a;
        int          rc;
        a  = 32'h0001_2348;
        rc = rd_count;
        read_check("miss read", a);
        check("miss read count", rc + 1, rd_count);
        check("miss line aligned", {a[31:4], 4'h0}, last_rd_addr);
        read_check("hit read", {a[31:4], 4'h4});
        check("hit read count", rc + 1, rd_count);
        check("hit latency", 1, done_lat);
    endtask

    task automatic test_write_hit();
        logic [31:0] b;
        int          rc;
        b = 32'h0004_5670;
        read_check("fill line", b);
        rc = rd_count;
        write_check("byte write", b + 32'h5, 4'b0010, 32'h0000_ab00);
        write_check("halfword write", b + 32'he, 4'b1100, 32'hbeef_0000);
        read_check("byte readback", b + 32'h4);
        read_check("halfword readback", b + 32'hc);
        check("write hit no refill", rc, rd_count);
    endtask

    task automatic test_write_miss();
        logic [31:0] c;
        int          rc;
        c  = 32'h0008_9ab4;
        rc = rd_count;
        write_check("miss write", c, 4'b0101, 32'h00cc_00dd);
        check("miss write no alloc", rc, rd_count);
        read_check("miss write readback", c);
        check("miss write refill count", rc + 1, rd_count);
    endtask

    // three tags on one index, more than the two ways hold
    task automatic test_eviction();
        logic [31:0] base [3];
        logic [31:0] a;
        logic [31:0] r;
        logic [31:0] d;
        base = '{32'h0010_0a00, 32'h0020_0a00, 32'h0030_0a00};
        for (int i = 0; i < 48; i++) begin
            r = $random(seed);
            d = $random(seed);
            a = base[(i + int'(r[9:8])) % 3];
            a[3:2] = r[3:2];
            if (r[4]) write_check("evict write", a, r[8:5] | 4'b0001, d);
            else read_check("evict read", a);
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] d;
        logic [31:0] held;
        int          t;
        d = 32'h000c_def8;
        rd_hold = 1'b1;
        issue_req(1'b0, d, 4'hf, 32'h0);
        t = 0;
        while (!rd_req) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) report_timeout("rd_req under back-pressure");
        end
        held = rd_addr;
        check("stall line aligned", {d[31:4], 4'h0}, held);
        for (int i = 0; i < 20; i++) begin
            @(posedge clk);
            check("stall rd_req", 1'b1, rd_req);
            check("stall rd_addr", held, rd_addr);
            check("stall ready", 1'b0, ready);
        end
        @(negedge clk);
        rd_hold = 1'b0;
        wait_done();
        check("stall read data", exp_word(d), done_data);
    endtask

    initial begin
        rst       = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        rd_hold   = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_read_miss_hit();
        test_write_hit();
        test_write_miss();
        test_eviction();
        test_backpressure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: dcache.f
hw/dcache_pkg.sv
hw/dcache_ram.sv
hw/dcache_way.sv
hw/dcache_victim_lfsr.sv
hw/dcache_ctrl.sv
hw/wt_dcache.sv
tests/dcache_mem_model.sv
tests/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= dcache.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
